// File: verilog/u1e_bus_pkg.sv
package u1e_bus_pkg;

   ////////////////////
   // Bus geometry
   ////////////////////

   // One 16-bit word per access
   localparam int DW = 16;

   // Word address seen by the host
   localparam int AW = 11;

   // Top address bits that pick a slave
   localparam int DECODE_W = 4;

   ////////////////////
   // Slave numbers
   ////////////////////

   // Misc registers, LEDs and switches
   localparam logic [3:0] SLAVE_MISC = 4'd0;

   // Debug UART transmitter
   localparam logic [3:0] SLAVE_UART = 4'd1;

endpackage

// File: verilog/u1e_regs_pkg.sv
package u1e_regs_pkg;

   ////////////////////
   // Misc slave map
   ////////////////////

   localparam logic [6:0] REG_FAST     = 7'd4;
   localparam logic [6:0] REG_SWITCHES = 7'd5;

   // Returned for every unused misc index
   localparam logic [15:0] MISC_MARKER = 16'hBEEF;

   ////////////////////
   // UART slave map
   ////////////////////

   localparam logic [6:0] UART_DATA   = 7'd0;
   localparam logic [6:0] UART_STATUS = 7'd1;
   localparam logic [6:0] UART_CLKDIV = 7'd2;

   // Host bridge sequencing
   typedef enum logic [1:0] {BR_IDLE, BR_CYCLE, BR_DONE} bridge_state_t;

   // Serial frame position
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_state_t;

endpackage

// File: verilog/host_wb_bridge.sv
module host_wb_bridge #(
   parameter int DW       = u1e_bus_pkg::DW,
   parameter int AW       = u1e_bus_pkg::AW,
   parameter int DECODE_W = u1e_bus_pkg::DECODE_W
) (
   input  logic          wb_clk,
   input  logic          rst_n_i,
   input  logic          host_req_i,
   input  logic          host_we_i,
   input  logic [AW-1:0] host_adr_i,
   input  logic [DW-1:0] host_wdat_i,
   output logic [DW-1:0] host_rdat_o,
   output logic          host_done_o,
   output logic          host_busy_o,
   input  logic          wb_ack_i,
   input  logic [DW-1:0] wb_dat_i,
   output logic          wb_cyc_o,
   output logic          wb_stb_o,
   output logic          wb_we_o,
   output logic [AW-1:0] wb_adr_o,
   output logic [DW-1:0] wb_dat_o
);

   u1e_regs_pkg::bridge_state_t state_q;

   // Slave field and offset within the slave
   logic [DECODE_W-1:0]    slv_q;
   logic [AW-DECODE_W-1:0] ofs_q;
   logic                   we_q;
   logic [DW-1:0]          wdat_q;
   logic [DW-1:0]          rdat_q;

   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         state_q <= u1e_regs_pkg::BR_IDLE;
      end else begin
         case (state_q)
            u1e_regs_pkg::BR_IDLE:  if (host_req_i) state_q <= u1e_regs_pkg::BR_CYCLE;
            u1e_regs_pkg::BR_CYCLE: if (wb_ack_i) state_q <= u1e_regs_pkg::BR_DONE;
            u1e_regs_pkg::BR_DONE:  state_q <= u1e_regs_pkg::BR_IDLE;
            default:                state_q <= u1e_regs_pkg::BR_IDLE;
         endcase
      end
   end

   // Request latch and read capture
   always_ff @(posedge wb_clk) begin
      if (state_q == u1e_regs_pkg::BR_IDLE && host_req_i) begin
         we_q   <= host_we_i;
         slv_q  <= host_adr_i[AW-1 -: DECODE_W];
         ofs_q  <= host_adr_i[AW-DECODE_W-1:0];
         wdat_q <= host_wdat_i;
      end
      // Writes leave the last read word in place
      if (state_q == u1e_regs_pkg::BR_CYCLE && wb_ack_i && !we_q)
         rdat_q <= wb_dat_i;
   end

   assign wb_cyc_o    = (state_q == u1e_regs_pkg::BR_CYCLE);
   assign wb_stb_o    = (state_q == u1e_regs_pkg::BR_CYCLE);
   assign wb_we_o     = we_q;
   assign wb_adr_o    = {slv_q, ofs_q};
   assign wb_dat_o    = wdat_q;
   assign host_rdat_o = rdat_q;
   assign host_done_o = (state_q == u1e_regs_pkg::BR_DONE);
   assign host_busy_o = (state_q != u1e_regs_pkg::BR_IDLE);

endmodule

// File: verilog/wb_1master_decode.sv
module wb_1master_decode #(
   parameter int DW       = u1e_bus_pkg::DW,
   parameter int AW       = u1e_bus_pkg::AW,
   parameter int DECODE_W = u1e_bus_pkg::DECODE_W
) (
   input  logic          wb_clk,
   input  logic          rst_n_i,
   input  logic          m_cyc_i,
   input  logic          m_stb_i,
   input  logic          m_we_i,
   input  logic [AW-1:0] m_adr_i,
   input  logic [DW-1:0] m_dat_i,
   output logic [DW-1:0] m_dat_o,
   output logic          m_ack_o,
   input  logic [DW-1:0] s0_dat_i,
   input  logic          s0_ack_i,
   input  logic [DW-1:0] s1_dat_i,
   input  logic          s1_ack_i,
   output logic          s0_cyc_o,
   output logic          s0_stb_o,
   output logic          s0_we_o,
   output logic [6:0]    s0_adr_o,
   output logic [DW-1:0] s0_dat_o,
   output logic          s1_cyc_o,
   output logic          s1_stb_o,
   output logic          s1_we_o,
   output logic [6:0]    s1_adr_o,
   output logic [DW-1:0] s1_dat_o
);

   logic [DECODE_W-1:0] slave;
   logic                hit0;
   logic                hit1;

   assign slave    = m_adr_i[AW-1 -: DECODE_W];
   assign hit0     = (slave == DECODE_W'(u1e_bus_pkg::SLAVE_MISC));
   assign hit1     = (slave == DECODE_W'(u1e_bus_pkg::SLAVE_UART));

   // Shared signals fan out, stb goes to one slave only
   assign s0_cyc_o = m_cyc_i;
   assign s0_stb_o = m_stb_i && hit0;
   assign s0_we_o  = m_we_i;
   assign s0_adr_o = m_adr_i[6:0];
   assign s0_dat_o = m_dat_i;
   assign s1_cyc_o = m_cyc_i;
   assign s1_stb_o = m_stb_i && hit1;
   assign s1_we_o  = m_we_i;
   assign s1_adr_o = m_adr_i[6:0];
   assign s1_dat_o = m_dat_i;

   // Unmapped slaves answer at once with zero
   assign m_ack_o = hit0 ? s0_ack_i : hit1 ? s1_ack_i : (m_cyc_i && m_stb_i);
   assign m_dat_o = hit0 ? s0_dat_i : hit1 ? s1_dat_i : '0;

endmodule

// File: verilog/misc_regs.sv
module misc_regs #(
   parameter int DW = u1e_bus_pkg::DW
) (
   input  logic          wb_clk,
   input  logic          rst_n_i,
   input  logic          cyc_i,
   input  logic          stb_i,
   input  logic          we_i,
   input  logic [6:0]    adr_i,
   input  logic [DW-1:0] dat_i,
   input  logic [7:0]    dip_sw_i,
   input  logic [2:0]    push_btn_i,
   output logic [DW-1:0] dat_o,
   output logic          ack_o,
   output logic [2:0]    leds_o
);

   logic [DW-1:0] reg_fast_q;

   always_ff @(posedge wb_clk) begin
      if (!rst_n_i)
         reg_fast_q <= '0;
      else if (cyc_i && stb_i && we_i && adr_i == u1e_regs_pkg::REG_FAST)
         reg_fast_q <= dat_i;
   end

   always_comb begin
      if (adr_i == u1e_regs_pkg::REG_FAST)
         dat_o = reg_fast_q;
      else if (adr_i == u1e_regs_pkg::REG_SWITCHES)
         dat_o = DW'({5'b0, push_btn_i, dip_sw_i});
      else
         dat_o = DW'(u1e_regs_pkg::MISC_MARKER);
   end

   assign ack_o = cyc_i && stb_i;

   // Board wiring swaps the two low LEDs
   assign {leds_o[2], leds_o[0], leds_o[1]} = reg_fast_q[2:0];

endmodule

// File: verilog/uart_tx.sv
module uart_tx #(
   parameter int DW             = u1e_bus_pkg::DW,
   parameter int CLKDIV_DEFAULT = 278
) (
   input  logic          wb_clk,
   input  logic          rst_n_i,
   input  logic          cyc_i,
   input  logic          stb_i,
   input  logic          we_i,
   input  logic [6:0]    adr_i,
   input  logic [DW-1:0] dat_i,
   output logic [DW-1:0] dat_o,
   output logic          ack_o,
   output logic          uart_txd_o
);

   u1e_regs_pkg::uart_state_t state_q;

   logic [DW-1:0] clkdiv_q;
   logic          overrun_q;
   logic [DW-1:0] div_lat_q;
   logic [DW-1:0] cnt_q;
   logic [2:0]    bit_q;
   logic [7:0]    shift_q;
   logic          txd_q;
   logic          wr;
   logic          idle;
   logic          start;
   logic          bit_end;

   assign wr      = cyc_i && stb_i && we_i;
   assign idle    = (state_q == u1e_regs_pkg::TX_IDLE);
   assign start   = wr && adr_i == u1e_regs_pkg::UART_DATA && idle;
   assign bit_end = (cnt_q == div_lat_q - 1'b1);

   ////////////////////
   // Register writes
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         clkdiv_q  <= DW'(CLKDIV_DEFAULT);
         overrun_q <= 1'b0;
      end else if (wr) begin
         if (adr_i == u1e_regs_pkg::UART_CLKDIV)
            clkdiv_q <= dat_i;
         // Sticky until status is written
         if (adr_i == u1e_regs_pkg::UART_DATA && !idle)
            overrun_q <= 1'b1;
         else if (adr_i == u1e_regs_pkg::UART_STATUS)
            overrun_q <= 1'b0;
      end
   end

   ////////////////////
   // Frame FSM
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         state_q <= u1e_regs_pkg::TX_IDLE;
         txd_q   <= 1'b1;
         cnt_q   <= '0;
         bit_q   <= '0;
      end else begin
         cnt_q <= (idle || bit_end) ? '0 : cnt_q + 1'b1;
         case (state_q)
            u1e_regs_pkg::TX_IDLE: if (start) begin
               state_q <= u1e_regs_pkg::TX_START;
               txd_q   <= 1'b0;
               bit_q   <= '0;
            end
            u1e_regs_pkg::TX_START: if (bit_end) begin
               state_q <= u1e_regs_pkg::TX_DATA;
               txd_q   <= shift_q[0];
            end
            u1e_regs_pkg::TX_DATA: if (bit_end) begin
               if (bit_q == 3'd7) begin
                  state_q <= u1e_regs_pkg::TX_STOP;
                  txd_q   <= 1'b1;
               end else begin
                  bit_q <= bit_q + 1'b1;
                  txd_q <= shift_q[1];
               end
            end
            u1e_regs_pkg::TX_STOP: if (bit_end) state_q <= u1e_regs_pkg::TX_IDLE;
            default: state_q <= u1e_regs_pkg::TX_IDLE;
         endcase
      end
   end

   // Byte and bit period for the running frame
   always_ff @(posedge wb_clk) begin
      if (start) begin
         shift_q   <= dat_i[7:0];
         div_lat_q <= clkdiv_q;
      end else if (state_q == u1e_regs_pkg::TX_DATA && bit_end) begin
         shift_q <= shift_q >> 1;
      end
   end

   always_comb begin
      case (adr_i)
         u1e_regs_pkg::UART_STATUS: dat_o = DW'({overrun_q, !idle});
         u1e_regs_pkg::UART_CLKDIV: dat_o = clkdiv_q;
         default:                   dat_o = '0;
      endcase
   end

   assign ack_o      = cyc_i && stb_i;
   assign uart_txd_o = txd_q;

endmodule

// File: verilog/u1e_core.sv
module u1e_core #(
   parameter int DW             = u1e_bus_pkg::DW,
   parameter int AW             = u1e_bus_pkg::AW,
   parameter int DECODE_W       = u1e_bus_pkg::DECODE_W,
   parameter int CLKDIV_DEFAULT = 278
) (
   input  logic          wb_clk,
   input  logic          rst_n_i,
   input  logic          host_req_i,
   input  logic          host_we_i,
   input  logic [AW-1:0] host_adr_i,
   input  logic [DW-1:0] host_wdat_i,
   input  logic [7:0]    dip_sw_i,
   input  logic [2:0]    push_btn_i,
   output logic [DW-1:0] host_rdat_o,
   output logic          host_done_o,
   output logic          host_busy_o,
   output logic [2:0]    leds_o,
   output logic          uart_txd_o
);

   logic          m_cyc, m_stb, m_we, m_ack;
   logic [AW-1:0] m_adr;
   logic [DW-1:0] m_dat_mosi, m_dat_miso;
   logic          s0_cyc, s0_stb, s0_we, s0_ack;
   logic          s1_cyc, s1_stb, s1_we, s1_ack;
   logic [6:0]    s0_adr, s1_adr;
   logic [DW-1:0] s0_dat_mosi, s0_dat_miso, s1_dat_mosi, s1_dat_miso;

   ////////////////////
   // Host to Wishbone
   ////////////////////

   host_wb_bridge #(.DW(DW), .AW(AW), .DECODE_W(DECODE_W)) bridge_i (
      .wb_clk(wb_clk), .rst_n_i(rst_n_i),
      .host_req_i(host_req_i), .host_we_i(host_we_i), .host_adr_i(host_adr_i),
      .host_wdat_i(host_wdat_i), .host_rdat_o(host_rdat_o),
      .host_done_o(host_done_o), .host_busy_o(host_busy_o),
      .wb_ack_i(m_ack), .wb_dat_i(m_dat_miso), .wb_cyc_o(m_cyc), .wb_stb_o(m_stb),
      .wb_we_o(m_we), .wb_adr_o(m_adr), .wb_dat_o(m_dat_mosi));

   wb_1master_decode #(.DW(DW), .AW(AW), .DECODE_W(DECODE_W)) decode_i (
      .wb_clk(wb_clk), .rst_n_i(rst_n_i),
      .m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_we_i(m_we), .m_adr_i(m_adr),
      .m_dat_i(m_dat_mosi), .m_dat_o(m_dat_miso), .m_ack_o(m_ack),
      .s0_dat_i(s0_dat_miso), .s0_ack_i(s0_ack), .s1_dat_i(s1_dat_miso), .s1_ack_i(s1_ack),
      .s0_cyc_o(s0_cyc), .s0_stb_o(s0_stb), .s0_we_o(s0_we), .s0_adr_o(s0_adr),
      .s0_dat_o(s0_dat_mosi), .s1_cyc_o(s1_cyc), .s1_stb_o(s1_stb), .s1_we_o(s1_we),
      .s1_adr_o(s1_adr), .s1_dat_o(s1_dat_mosi));

   ////////////////////
   // Slaves
   ////////////////////

   misc_regs #(.DW(DW)) misc_i (
      .wb_clk(wb_clk), .rst_n_i(rst_n_i),
      .cyc_i(s0_cyc), .stb_i(s0_stb), .we_i(s0_we), .adr_i(s0_adr), .dat_i(s0_dat_mosi),
      .dip_sw_i(dip_sw_i), .push_btn_i(push_btn_i),
      .dat_o(s0_dat_miso), .ack_o(s0_ack), .leds_o(leds_o));

   // 278 gives 230.4k baud from a 64 MHz clock
   uart_tx #(.DW(DW), .CLKDIV_DEFAULT(CLKDIV_DEFAULT)) uart_i (
      .wb_clk(wb_clk), .rst_n_i(rst_n_i),
      .cyc_i(s1_cyc), .stb_i(s1_stb), .we_i(s1_we), .adr_i(s1_adr), .dat_i(s1_dat_mosi),
      .dat_o(s1_dat_miso), .ack_o(s1_ack), .uart_txd_o(uart_txd_o));

endmodule

// File: sim/u1e_core_props.sv
module u1e_core_props (
   input logic wb_clk,
   input logic rst_n_i,
   input logic req_i,
   input logic busy_i,
   input logic done_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i
);

   // Slaves only answer inside a bus cycle
   ack_in_cycle: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      ack_i |-> cyc_i && stb_i) else $error("Wishbone ack outside a cycle");

   done_one_cycle: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      done_i |=> !done_i) else $error("host done held longer than one cycle");

   // Bridge closes the cycle right after ack
   cyc_drops_after_ack: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      cyc_i && ack_i |=> !cyc_i) else $error("cyc still high after ack");

   done_after_req: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      req_i && !busy_i |-> ##2 done_i) else $error("host done not two cycles after request");

endmodule

bind host_wb_bridge u1e_core_props props_i (
   .wb_clk(wb_clk), .rst_n_i(rst_n_i), .req_i(host_req_i), .busy_i(host_busy_o),
   .done_i(host_done_o), .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .ack_i(wb_ack_i));

// File: sim/u1e_core_tb.sv
module u1e_core_tb;

   localparam int DW             = u1e_bus_pkg::DW;
   localparam int AW             = u1e_bus_pkg::AW;
   localparam int NUM_ACCESSES   = 300;
   localparam int TIMEOUT_CYCLES = NUM_ACCESSES * (2 + 70) + 2000;

   logic          wb_clk;
   logic          rst_n_i;
   logic          host_req_i;
   logic          host_we_i;
   logic [AW-1:0] host_adr_i;
   logic [DW-1:0] host_wdat_i;
   logic [7:0]    dip_sw_i;
   logic [2:0]    push_btn_i;
   logic [DW-1:0] host_rdat_o;
   logic          host_done_o;
   logic          host_busy_o;
   logic [2:0]    leds_o;
   logic          uart_txd_o;

   int          seed   = 32'hcda04637;
   int          cycles = 0;
   int          frames = 0;
   // Reference model
   logic [15:0] fast_m;
   int          div_m;
   logic        overrun_m;
   logic [15:0] last_rdat_m;
   logic        have_read;
   int          tx_div;
   int          tx_end;
   logic [7:0]  exp_bytes[$];

   u1e_core #(.CLKDIV_DEFAULT(6)) dut_i (
      .wb_clk(wb_clk), .rst_n_i(rst_n_i), .host_req_i(host_req_i), .host_we_i(host_we_i),
      .host_adr_i(host_adr_i), .host_wdat_i(host_wdat_i), .dip_sw_i(dip_sw_i),
      .push_btn_i(push_btn_i), .host_rdat_o(host_rdat_o), .host_done_o(host_done_o),
      .host_busy_o(host_busy_o), .leds_o(leds_o), .uart_txd_o(uart_txd_o));

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   ////////////////////
   // Model
   ////////////////////

   // edge_no is the clock edge that ends the ack cycle
   task automatic predict_access(input logic we, input logic [3:0] slv, input logic [6:0] ofs,
                                 input logic [15:0] wdat, input int edge_no,
                                 output logic [15:0] exp_rdat);
      logic tx_busy;
      tx_busy  = (edge_no <= tx_end);
      exp_rdat = 16'h0000;
      if (slv == u1e_bus_pkg::SLAVE_MISC) begin
         if (we && ofs == u1e_regs_pkg::REG_FAST)
            fast_m = wdat;
         if (ofs == u1e_regs_pkg::REG_FAST)
            exp_rdat = fast_m;
         else if (ofs == u1e_regs_pkg::REG_SWITCHES)
            exp_rdat = {5'b0, push_btn_i, dip_sw_i};
         else
            exp_rdat = 16'hBEEF;
      end else if (slv == u1e_bus_pkg::SLAVE_UART) begin
         if (we && ofs == u1e_regs_pkg::UART_DATA) begin
            if (tx_busy) begin
               overrun_m = 1'b1;
            end else begin
               exp_bytes.push_back(wdat[7:0]);
               tx_div = div_m;
               tx_end = edge_no + 10 * div_m;
            end
         end else if (we && ofs == u1e_regs_pkg::UART_STATUS) begin
            overrun_m = 1'b0;
         end else if (we && ofs == u1e_regs_pkg::UART_CLKDIV) begin
            div_m = int'(wdat);
         end
         if (ofs == u1e_regs_pkg::UART_STATUS)
            exp_rdat = {14'b0, overrun_m, tx_busy};
         else if (ofs == u1e_regs_pkg::UART_CLKDIV)
            exp_rdat = 16'(div_m);
      end
      // Writes keep the last read word on the host port
      if (we) begin
         exp_rdat = last_rdat_m;
      end else begin
         last_rdat_m = exp_rdat;
         have_read   = 1'b1;
      end
   endtask

   task automatic run_access(input logic we, input logic [3:0] slv, input logic [6:0] ofs,
                             input logic [15:0] wdat);
      logic [15:0] exp_rdat;
      int          waited;
      host_req_i  = 1'b1;
      host_we_i   = we;
      host_adr_i  = {slv, ofs};
      host_wdat_i = wdat;
      @(negedge wb_clk);
      host_req_i = 1'b0;
      predict_access(we, slv, ofs, wdat, cycles + 1, exp_rdat);
      waited = 1;
      while (!host_done_o && waited < 6) begin
         assert (host_busy_o)
         else abort_run($sformatf("FAIL %0t: busy low before done", $time));
         @(negedge wb_clk);
         waited++;
      end
      assert (host_done_o && host_busy_o && waited == 2)
      else abort_run($sformatf("FAIL %0t: done after %0d cycles, expected 2", $time, waited));
      assert (!have_read || host_rdat_o == exp_rdat)
      else abort_run($sformatf("FAIL %0t: adr 0x%h we %0b read 0x%h, expected 0x%h",
                               $time, {slv, ofs}, we, host_rdat_o, exp_rdat));
      assert (leds_o == {fast_m[2], fast_m[0], fast_m[1]})
      else abort_run($sformatf("FAIL %0t: leds 0x%h for fast reg 0x%h", $time, leds_o, fast_m));
      @(negedge wb_clk);
      assert (!host_done_o && !host_busy_o)
      else abort_run($sformatf("FAIL %0t: done or busy still high after access", $time));
   endtask

   ////////////////////
   // Checkers
   ////////////////////

   initial begin : watchdog
      forever begin
         @(posedge wb_clk);
         cycles++;
         if (cycles >= TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout: run still going after %0d cycles", cycles));
      end
   end

   // Samples each serial bit in the middle of its period
   initial begin : uart_monitor
      logic [7:0] got;
      logic [7:0] want;
      int         d;
      int         i;
      @(posedge rst_n_i);
      forever begin
         @(negedge uart_txd_o);
         d = tx_div;
         repeat (d / 2 + 1) @(negedge wb_clk);
         assert (uart_txd_o == 1'b0)
         else abort_run($sformatf("FAIL %0t: start bit not low", $time));
         for (i = 0; i < 8; i++) begin
            repeat (d) @(negedge wb_clk);
            got[i] = uart_txd_o;
         end
         repeat (d) @(negedge wb_clk);
         assert (uart_txd_o == 1'b1)
         else abort_run($sformatf("FAIL %0t: stop bit not high", $time));
         assert (exp_bytes.size() > 0)
         else abort_run("A UART frame was sent without an accepted data write");
         want = exp_bytes.pop_front();
         assert (got == want)
         else abort_run($sformatf("FAIL %0t: UART byte 0x%h, expected 0x%h", $time, got, want));
         frames++;
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin : stimulus
      logic [31:0] rnd;
      logic [31:0] rnd2;
      logic [3:0]  slv;
      logic [6:0]  ofs;
      logic [15:0] wdat;
      int          gap;
      int          n;
      rst_n_i     = 1'b0;
      host_req_i  = 1'b0;
      host_we_i   = 1'b0;
      host_adr_i  = '0;
      host_wdat_i = '0;
      dip_sw_i    = 8'h00;
      push_btn_i  = 3'b000;
      fast_m      = 16'h0000;
      div_m       = 6;
      overrun_m   = 1'b0;
      last_rdat_m = 16'h0000;
      have_read   = 1'b0;
      tx_div      = 6;
      tx_end      = 0;
      repeat (2) @(negedge wb_clk);
      rst_n_i = 1'b1;
      @(negedge wb_clk);
      assert (!host_done_o && !host_busy_o && uart_txd_o && leds_o == 3'b000)
      else abort_run($sformatf("FAIL %0t: outputs wrong after reset", $time));
      for (n = 0; n < NUM_ACCESSES; n++) begin
         rnd  = $random(seed);
         rnd2 = $random(seed);
         if (rnd[3:0] < 4'd3) begin
            dip_sw_i   = rnd2[23:16];
            push_btn_i = rnd2[26:24];
         end
         // Mostly the two real slaves, the rest anywhere in the map
         if (rnd[6:4] < 3'd3)
            slv = u1e_bus_pkg::SLAVE_MISC;
         else if (rnd[6:4] < 3'd6)
            slv = u1e_bus_pkg::SLAVE_UART;
         else
            slv = rnd[10:7];
         if (rnd[12:11] == 2'd0)
            ofs = rnd[19:13];
         else if (slv == u1e_bus_pkg::SLAVE_MISC)
            ofs = rnd[13] ? u1e_regs_pkg::REG_FAST : u1e_regs_pkg::REG_SWITCHES;
         else
            ofs = {5'b0, rnd[14:13]};
         wdat = rnd2[15:0];
         if (slv == u1e_bus_pkg::SLAVE_UART && ofs == u1e_regs_pkg::UART_CLKDIV)
            wdat = 16'd4 + wdat % 16'd7;
         run_access(rnd[20], slv, ofs, wdat);
         gap = (rnd[23:21] == 3'd0) ? int'(rnd[29:24]) : 0;
         repeat (gap) @(negedge wb_clk);
      end
      // Let the last frame run out
      while (cycles <= tx_end + 2)
         @(negedge wb_clk);
      assert (exp_bytes.size() == 0 && uart_txd_o)
      else abort_run($sformatf("FAIL %0t: %0d UART bytes never sent", $time, exp_bytes.size()));
      assert (frames > 0)
      else abort_run("No UART frame was sent during the run");
      $display("Checked %0d accesses and %0d UART frames", NUM_ACCESSES, frames);
      $display("All tests passed");
      $finish;
   end

endmodule

// File: project.f
verilog/u1e_bus_pkg.sv
verilog/u1e_regs_pkg.sv
verilog/host_wb_bridge.sv
verilog/wb_1master_decode.sv
verilog/misc_regs.sv
verilog/uart_tx.sv
verilog/u1e_core.sv
sim/u1e_core_props.sv
sim/u1e_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module u1e_core_tb

./obj_dir/Vu1e_core_tb | tee sim.log

grep -q "All tests passed" sim.log
